//--- filelist.f
+incdir+src
src/uart_pkg.sv
src/axil_pkg.sv
src/uart_baud_timer.sv
src/uart_rx_fsm.sv
src/uart_rx_deser.sv
src/uart_rx_fifo.sv
src/uart_axil_regs.sv
src/uart_rx_top.sv
verification/uart_rx_sva.sv
verification/uart_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the UART receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module uart_rx_tb -o sim_uart_rx
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_uart_rx)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qF "All tests passed!"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- verification/uart_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "uart_config.svh"

module uart_rx_tb
    import uart_pkg::*;
    import axil_pkg::*;
();

    localparam int BIT_CYCLES = `UART_BIT_CYCLES;
    localparam int DEPTH      = `UART_FIFO_DEPTH;
    localparam int NUM_FRAMES = 1 + 20 + 2 + 1 + DEPTH + 2;  // glitch counted as a frame
    localparam int BUS_OPS    = 90;                            // reads and writes, rounded up
    localparam int MAX_CYCLES = NUM_FRAMES * 11 * BIT_CYCLES + BUS_OPS * 8 + 200;

    logic        sys_clk;
    logic        rst_n;
    logic        uart_rxd;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;

    uart_frame_t model_q[$];                      // expected FIFO contents
    logic        model_ovr;
    logic [31:0] exp_addr;
    axil_rdata_u exp_word;
    axil_rdata_u act_word;
    logic [1:0]  exp_resp;
    logic [1:0]  act_resp;
    event        read_done;
    int          reads_issued = 0;
    int          reads_checked = 0;
    int          cycle_cnt = 0;

    uart_rx_top UUT (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .uart_rxd(uart_rxd),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp)
    );

    initial begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;           // 25 MHz
    end

    // ******************************************************************
    // failure reporting and compare tasks
    // ******************************************************************
    task automatic abort_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_frame(input string name, input uart_frame_t got, input uart_frame_t exp);
        if (got !== exp) begin
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_status(input string name, input fifo_status_t got,
                                input fifo_status_t exp);
        if (got !== exp) begin
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input axil_rdata_u got, input axil_rdata_u exp);
        if (got !== exp) begin
            $display("error: %s got 0x%08h expected 0x%08h", name, got, exp);
            abort_run();
        end
    endtask

    // ******************************************************************
    // reference model
    // ******************************************************************
    function automatic axil_rdata_u expected_rdata(input logic [31:0] addr);
        axil_rdata_u w;
        w = '0;
        if (addr == ADDR_RXDATA) begin
            if (model_q.size() == 0) begin
                w.rxdata.empty = 1'b1;            // marker only, byte zero
            end else begin
                w.rxdata.frame_err = model_q[0].frame_err;
                w.rxdata.data      = model_q[0].data;
            end
        end else if (addr == ADDR_STATUS) begin
            w.status.overrun = model_ovr;
            w.status.full    = (model_q.size() == DEPTH);
            w.status.empty   = (model_q.size() == 0);
            w.status.count   = FIFO_CNT_W'(model_q.size());
        end
        return w;                                 // unmapped reads give zero
    endfunction

    function automatic logic [1:0] expected_resp(input logic [31:0] addr);
        if (addr == ADDR_RXDATA || addr == ADDR_STATUS) begin
            return RESP_OKAY;
        end
        return RESP_SLVERR;
    endfunction

    function automatic void model_push(input uart_frame_t f);
        if (model_q.size() < DEPTH) begin
            model_q.push_back(f);
        end else begin
            model_ovr = 1'b1;                     // dropped, sticky flag
        end
    endfunction

    // ******************************************************************
    // serial and bus drivers
    // ******************************************************************
    task automatic send_frame(input logic [7:0] data, input logic bad_stop);
        uart_frame_t f;
        int          i;
        @(negedge sys_clk);
        uart_rxd = 1'b0;                          // start bit
        repeat (BIT_CYCLES) @(negedge sys_clk);
        for (i = 0; i < 8; i++) begin
            uart_rxd = data[i];                   // LSB first
            repeat (BIT_CYCLES) @(negedge sys_clk);
        end
        uart_rxd = ~bad_stop;
        repeat (BIT_CYCLES) @(negedge sys_clk);
        uart_rxd = 1'b1;                          // one idle bit
        repeat (BIT_CYCLES) @(negedge sys_clk);
        f.frame_err = bad_stop;
        f.data      = data;
        model_push(f);
    endtask

    task automatic send_glitch(input int low_cycles);
        @(negedge sys_clk);
        uart_rxd = 1'b0;
        repeat (low_cycles) @(negedge sys_clk);
        uart_rxd = 1'b1;
        repeat (2 * BIT_CYCLES) @(negedge sys_clk);
    endtask

    task automatic bus_read(input logic [31:0] addr);
        exp_addr = addr;
        exp_word = expected_rdata(addr);          // model state before the pop
        exp_resp = expected_resp(addr);
        reads_issued++;
        @(negedge sys_clk);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        @(negedge sys_clk);
        while (!axil_rsp.arready) @(negedge sys_clk);
        @(negedge sys_clk);                       // address taken on this edge
        axil_req.arvalid = 1'b0;
        while (!axil_rsp.rvalid) @(negedge sys_clk);
        act_word = axil_rsp.rdata;
        act_resp = axil_rsp.rresp;
        axil_req.rready = 1'b1;
        -> read_done;
        @(negedge sys_clk);
        axil_req.rready = 1'b0;
        if (addr == ADDR_RXDATA && model_q.size() != 0) begin
            void'(model_q.pop_front());
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        @(negedge sys_clk);
        axil_req.awaddr  = addr;                  // held past accept, w1c decode
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hf;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        @(negedge sys_clk);
        while (!(axil_rsp.awready && axil_rsp.wready)) @(negedge sys_clk);
        @(negedge sys_clk);                       // address and data taken
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        while (!axil_rsp.bvalid) @(negedge sys_clk);
        check_resp("bresp", axil_rsp.bresp, RESP_OKAY);
        axil_req.bready = 1'b1;
        @(negedge sys_clk);
        axil_req.bready = 1'b0;
        if (addr == ADDR_STATUS && data[0]) begin
            model_ovr = 1'b0;
        end
    endtask

    // every completed read checked here
    initial begin
        uart_frame_t  got_f;
        uart_frame_t  exp_f;
        fifo_status_t got_s;
        fifo_status_t exp_s;
        forever begin
            @(read_done);
            check_resp("rresp", act_resp, exp_resp);
            if (exp_addr == ADDR_RXDATA) begin
                got_f.frame_err = act_word.rxdata.frame_err;
                got_f.data      = act_word.rxdata.data;
                exp_f.frame_err = exp_word.rxdata.frame_err;
                exp_f.data      = exp_word.rxdata.data;
                check_frame("rxdata frame", got_f, exp_f);
                check_word("rxdata word", act_word, exp_word);  // empty marker, zero rsvd
            end else if (exp_addr == ADDR_STATUS) begin
                got_s = {act_word.status.overrun, act_word.status.full,
                         act_word.status.empty, act_word.status.count};
                exp_s = {exp_word.status.overrun, exp_word.status.full,
                         exp_word.status.empty, exp_word.status.count};
                check_status("status", got_s, exp_s);
            end else begin
                check_word("unmapped rdata", act_word, exp_word);
            end
            reads_checked++;
        end
    end

    // run limit
    always @(posedge sys_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("error: run did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    // ******************************************************************
    // test sequence
    // ******************************************************************
    initial begin
        logic [7:0] rnd_byte;
        int         k;
        void'($urandom(32'h00512d92));
        rst_n     = 1'b0;
        uart_rxd  = 1'b1;                         // line idles high
        axil_req  = '0;
        model_ovr = 1'b0;
        repeat (3) @(posedge sys_clk);
        @(negedge sys_clk);
        rst_n = 1'b1;
        repeat (2) @(negedge sys_clk);

        send_frame(8'h5a, 1'b0);                  // single byte
        bus_read(ADDR_RXDATA);
        bus_read(ADDR_STATUS);

        for (k = 0; k < 10; k++) begin            // random pairs
            rnd_byte = 8'($urandom());
            send_frame(rnd_byte, 1'b0);
            rnd_byte = 8'($urandom());
            send_frame(rnd_byte, 1'b0);
            bus_read(ADDR_STATUS);
            bus_read(ADDR_RXDATA);
            bus_read(ADDR_STATUS);
            bus_read(ADDR_RXDATA);
        end

        send_frame(8'ha5, 1'b1);                  // low stop bit
        send_frame(8'h3c, 1'b0);
        bus_read(ADDR_STATUS);
        bus_read(ADDR_RXDATA);
        bus_read(ADDR_RXDATA);

        send_glitch(BIT_CYCLES / 4);              // short low pulse
        bus_read(ADDR_STATUS);
        bus_read(ADDR_RXDATA);                    // empty marker

        for (k = 0; k < DEPTH + 2; k++) begin     // overflow
            send_frame(8'(8'h80 + k), 1'b0);
        end
        bus_read(ADDR_STATUS);
        for (k = 0; k < DEPTH; k++) begin
            bus_read(ADDR_RXDATA);
        end
        bus_write(32'h0000_000c, 32'h1);          // unmapped, no effect
        bus_read(ADDR_STATUS);
        bus_read(32'h0000_0008);                  // unmapped read
        bus_write(ADDR_STATUS, 32'h1);            // clear overrun
        bus_read(ADDR_STATUS);

        repeat (4) @(negedge sys_clk);
        if (reads_checked != reads_issued) begin
            $display("error: only %0d of %0d reads were checked", reads_checked, reads_issued);
            abort_run();
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verification/uart_rx_sva.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_sva
    import axil_pkg::*;
(
    input wire       sys_clk,
    input wire       rst_n,
    input axil_req_t axil_req,
    input axil_rsp_t axil_rsp
);

    // ******************************************************************
    // bus handshake rules
    // ******************************************************************
    property rvalid_hold_p;                       // read payload frozen until rready
        @(posedge sys_clk) disable iff (!rst_n)
        axil_rsp.rvalid && !axil_req.rready |=>
            axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp);
    endproperty

    property bvalid_hold_p;                       // write response held until bready
        @(posedge sys_clk) disable iff (!rst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp);
    endproperty

    property no_ar_while_r_p;                     // read back-pressure
        @(posedge sys_clk) disable iff (!rst_n)
        axil_rsp.arready |-> !axil_rsp.rvalid;
    endproperty

    property reset_quiet_p;                       // handshake outputs low out of reset
        @(posedge sys_clk)
        !rst_n |=> !(axil_rsp.awready || axil_rsp.wready || axil_rsp.bvalid ||
                     axil_rsp.arready || axil_rsp.rvalid);
    endproperty

    assert property (rvalid_hold_p) else $error("rvalid dropped or read payload changed early");
    assert property (bvalid_hold_p) else $error("bvalid dropped or bresp changed early");
    assert property (no_ar_while_r_p) else $error("arready high while rvalid high");
    assert property (reset_quiet_p) else $error("ready or valid high during reset");

endmodule

bind uart_rx_top uart_rx_sva u_sva (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .axil_req(axil_req),
    .axil_rsp(axil_rsp)
);

`default_nettype wire

//--- src/uart_rx_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "uart_config.svh"

module uart_rx_top
    import uart_pkg::*;
    import axil_pkg::*;
(
    input  wire       sys_clk,
    input  wire       rst_n,
    input  wire       uart_rxd,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp
);

    logic         rxd_sync;
    logic         start_edge;
    logic         timer_run;
    logic         mid_bit;
    logic [3:0]   bit_index;
    logic         sample_en;
    logic         stop_en;
    logic         wr_en;
    logic         rd_en;
    logic         clr_overrun;
    uart_frame_t  frame;                      // deserializer output
    uart_frame_t  rd_frame;                   // FIFO head
    fifo_status_t status;

    // ******************************************************************
    // receive path
    // ******************************************************************
    uart_rx_deser u_deser (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .uart_rxd  (uart_rxd),
        .sample_en (sample_en),
        .stop_en   (stop_en),
        .rxd_sync  (rxd_sync),
        .start_edge(start_edge),
        .frame     (frame)
    );

    uart_rx_fsm u_fsm (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .rxd_sync  (rxd_sync),
        .start_edge(start_edge),
        .mid_bit   (mid_bit),
        .bit_index (bit_index),
        .timer_run (timer_run),
        .sample_en (sample_en),
        .stop_en   (stop_en),
        .wr_en     (wr_en)
    );

    uart_baud_timer #(
        .BIT_CYCLES(`UART_BIT_CYCLES)
    ) u_timer (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .timer_run (timer_run),
        .mid_bit   (mid_bit),
        .bit_index (bit_index)
    );

    // ******************************************************************
    // buffering and bus
    // ******************************************************************
    uart_rx_fifo #(
        .DEPTH(`UART_FIFO_DEPTH)
    ) u_fifo (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_frame   (frame),
        .rd_en      (rd_en),
        .rd_frame   (rd_frame),
        .clr_overrun(clr_overrun),
        .status     (status)
    );

    uart_axil_regs u_regs (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .rd_frame   (rd_frame),
        .status     (status),
        .rd_en      (rd_en),
        .clr_overrun(clr_overrun)
    );

endmodule

`default_nettype wire

//--- src/uart_axil_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_axil_regs
    import uart_pkg::*;
    import axil_pkg::*;
(
    input  wire          sys_clk,
    input  wire          rst_n,
    input  axil_req_t    axil_req,
    output axil_rsp_t    axil_rsp,
    input  uart_frame_t  rd_frame,            // FIFO head
    input  fifo_status_t status,
    output logic         rd_en,               // pop FIFO
    output logic         clr_overrun
);

    logic                   awready;          // also drives wready
    logic                   bvalid;
    logic                   arready;
    logic                   rvalid;
    logic [1:0]             rresp;
    logic [AXIL_DATA_W-1:0] rdata;
    logic [AXIL_ADDR_W-1:0] ar_addr;          // latched read address
    logic                   wr_start;
    logic                   rd_start;
    axil_rdata_u            rd_word;
    logic                   rd_err;

    // ******************************************************************
    // write channel
    // ******************************************************************
    assign wr_start = axil_req.awvalid && axil_req.wvalid && !awready && !bvalid;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            awready <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= wr_start;              // one-cycle pulse
            if (awready) begin
                bvalid <= 1'b1;               // response after accept
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // w1c of overrun, unmapped writes dropped
    assign clr_overrun = awready && (axil_req.awaddr == ADDR_STATUS) && axil_req.wdata[0];

    // ******************************************************************
    // read channel
    // ******************************************************************
    assign rd_start = axil_req.arvalid && !arready && !rvalid; // stall while rvalid

    always_comb begin
        rd_word = '0;
        rd_err  = 1'b0;
        case (ar_addr)
            ADDR_RXDATA: begin
                rd_word.rxdata.empty = status.empty;
                if (!status.empty) begin
                    rd_word.rxdata.frame_err = rd_frame.frame_err;
                    rd_word.rxdata.data      = rd_frame.data;
                end
            end
            ADDR_STATUS: begin
                rd_word.status.overrun = status.overrun;
                rd_word.status.full    = status.full;
                rd_word.status.empty   = status.empty;
                rd_word.status.count   = status.count;
            end
            default: rd_err = 1'b1;           // unmapped, zero data
        endcase
    end

    // pop lands on the same edge rvalid rises
    assign rd_en = arready && (ar_addr == ADDR_RXDATA) && !status.empty;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= rd_start;
            if (arready) begin
                rvalid <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rd_start) begin
            ar_addr <= axil_req.araddr;
        end
        if (arready) begin                    // payload frozen until rready
            rdata <= rd_word;
            rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    // response bundle
    assign axil_rsp.awready = awready;
    assign axil_rsp.wready  = awready;
    assign axil_rsp.bresp   = RESP_OKAY;
    assign axil_rsp.bvalid  = bvalid;
    assign axil_rsp.arready = arready;
    assign axil_rsp.rdata   = rdata;
    assign axil_rsp.rresp   = rresp;
    assign axil_rsp.rvalid  = rvalid;

endmodule

`default_nettype wire

//--- src/uart_rx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_fifo
    import uart_pkg::*;
#(
    parameter int DEPTH = 8                   // power of two
) (
    input  wire          sys_clk,
    input  wire          rst_n,
    input  wire          wr_en,
    input  uart_frame_t  wr_frame,
    input  wire          rd_en,
    output uart_frame_t  rd_frame,            // head entry, show-ahead
    input  wire          clr_overrun,
    output fifo_status_t status
);

    localparam int AW = $clog2(DEPTH);

    uart_frame_t   mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;                     // 0..DEPTH
    logic          overrun;
    logic          full;
    logic          empty;
    logic          do_wr;
    logic          do_rd;

    assign full  = (count == (AW+1)'(DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;            // dropped when full
    assign do_rd = rd_en && !empty;           // ignored when empty

    // ******************************************************************
    // storage and pointers
    // ******************************************************************
    always_ff @(posedge sys_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_frame;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;   // wraps at DEPTH
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (wr_en && full) begin
                overrun <= 1'b1;              // set wins over clear
            end else if (clr_overrun) begin
                overrun <= 1'b0;
            end
        end
    end

    assign rd_frame       = mem[rd_ptr];
    assign status.overrun = overrun;
    assign status.full    = full;
    assign status.empty   = empty;
    assign status.count   = FIFO_CNT_W'(count);

endmodule

`default_nettype wire

//--- src/uart_rx_deser.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_deser
    import uart_pkg::*;
(
    input  wire         sys_clk,
    input  wire         rst_n,
    input  wire         uart_rxd,             // raw serial input
    input  wire         sample_en,
    input  wire         stop_en,
    output logic        rxd_sync,
    output logic        start_edge,
    output uart_frame_t frame
);

    logic       rxd_d0;                       // first sync stage
    logic       rxd_d1;                       // second sync stage
    logic       rxd_d2;                       // edge history
    logic [7:0] shift_reg;                    // data bits, LSB first

    // ******************************************************************
    // synchronizer and edge detect
    // ******************************************************************
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            rxd_d0 <= 1'b1;                   // line idles high
            rxd_d1 <= 1'b1;
            rxd_d2 <= 1'b1;
        end else begin
            rxd_d0 <= uart_rxd;
            rxd_d1 <= rxd_d0;
            rxd_d2 <= rxd_d1;
        end
    end

    assign rxd_sync   = rxd_d1;
    assign start_edge = rxd_d2 & ~rxd_d1;     // high to low

    // data path
    always_ff @(posedge sys_clk) begin
        if (sample_en) begin
            shift_reg <= {rxd_sync, shift_reg[7:1]};
        end
        if (stop_en) begin
            frame.data      <= shift_reg;
            frame.frame_err <= ~rxd_sync;     // stop bit must be high
        end
    end

endmodule

`default_nettype wire

//--- src/uart_rx_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_fsm
    import uart_pkg::*;
(
    input  wire        sys_clk,
    input  wire        rst_n,
    input  wire        rxd_sync,              // synchronized line
    input  wire        start_edge,            // falling edge pulse
    input  wire        mid_bit,
    input  wire  [3:0] bit_index,
    output logic       timer_run,
    output logic       sample_en,             // shift one data bit
    output logic       stop_en,               // latch byte and stop check
    output logic       wr_en                  // push frame into FIFO
);

    rx_state_e state;
    rx_state_e state_nxt;

    // ******************************************************************
    // next state
    // ******************************************************************
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (start_edge) begin
                    state_nxt = ST_START;
                end
            end
            ST_START: begin
                if (mid_bit) begin            // still low means real start bit
                    state_nxt = rxd_sync ? ST_IDLE : ST_DATA;
                end
            end
            ST_DATA: begin
                if (mid_bit && (bit_index == 4'd8)) begin // last data bit taken
                    state_nxt = ST_STOP;
                end
            end
            ST_STOP: begin
                if (mid_bit) begin            // early return, next edge can come
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            wr_en <= 1'b0;
        end else begin
            state <= state_nxt;
            wr_en <= (state == ST_STOP) && mid_bit; // frame valid one cycle on
        end
    end

    // timer runs through start, data and stop
    assign timer_run = (state != ST_IDLE);
    assign sample_en = (state == ST_DATA) && mid_bit;
    assign stop_en   = (state == ST_STOP) && mid_bit;

endmodule

`default_nettype wire

//--- src/uart_baud_timer.sv
`timescale 1ns/1ps
`default_nettype none

module uart_baud_timer #(
    parameter int BIT_CYCLES = 16                 // clocks per bit, at least 4
) (
    input  wire        sys_clk,
    input  wire        rst_n,
    input  wire        timer_run,                 // high for the length of a frame
    output logic       mid_bit,                   // one cycle, middle of each bit
    output logic [3:0] bit_index                  // 0 start, 1..8 data, 9 stop
);

    localparam int CNT_W = $clog2(BIT_CYCLES);

    logic [CNT_W-1:0] clk_cnt;                    // position inside the bit
    logic             bit_end;

    assign bit_end = (clk_cnt == CNT_W'(BIT_CYCLES - 1));

    // ******************************************************************
    // bit period counter
    // ******************************************************************
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            clk_cnt   <= '0;
            bit_index <= 4'd0;
        end else if (!timer_run) begin            // idle, hold at zero
            clk_cnt   <= '0;
            bit_index <= 4'd0;
        end else if (bit_end) begin               // wrap, next bit
            clk_cnt   <= '0;
            bit_index <= bit_index + 4'd1;
        end else begin
            clk_cnt   <= clk_cnt + 1'b1;
        end
    end

    // halfway point of the bit
    assign mid_bit = timer_run && (clk_cnt == CNT_W'(BIT_CYCLES / 2));

endmodule

`default_nettype wire

//--- src/axil_pkg.sv
`default_nettype none

package axil_pkg;

    localparam int AXIL_ADDR_W = 32;
    localparam int AXIL_DATA_W = 32;

    // register map
    localparam logic [AXIL_ADDR_W-1:0] ADDR_RXDATA = 32'h0000_0000; // pop one byte
    localparam logic [AXIL_ADDR_W-1:0] ADDR_STATUS = 32'h0000_0004; // count, flags, w1c

    // response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic [AXIL_ADDR_W-1:0]   awaddr;
        logic                     awvalid;
        logic [AXIL_DATA_W-1:0]   wdata;
        logic [AXIL_DATA_W/8-1:0] wstrb;   // not decoded
        logic                     wvalid;
        logic                     bready;
        logic [AXIL_ADDR_W-1:0]   araddr;
        logic                     arvalid;
        logic                     rready;
    } axil_req_t;

    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic [1:0]             bresp;
        logic                   bvalid;
        logic                   arready;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
        logic                   rvalid;
    } axil_rsp_t;

    // rxdata register view
    typedef struct packed {
        logic        empty;            // nothing popped, byte invalid
        logic [21:0] rsvd;
        logic        frame_err;
        logic [7:0]  data;
    } rxdata_view_t;

    // status register view
    typedef struct packed {
        logic [28-uart_pkg::FIFO_CNT_W:0] rsvd;
        logic                             overrun; // bit 7, write 1 to bit 0 clears
        logic                             full;
        logic                             empty;
        logic [uart_pkg::FIFO_CNT_W-1:0]  count;
    } status_view_t;

    typedef union packed {
        rxdata_view_t rxdata;
        status_view_t status;
    } axil_rdata_u;

endpackage

`default_nettype wire

//--- src/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // width of the FIFO occupancy field, covers depths up to 16
    localparam int FIFO_CNT_W = 5;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,               // line high, waiting for start edge
        ST_START = 2'd1,               // confirming start bit at mid-bit
        ST_DATA  = 2'd2,               // 8 data bits, LSB first
        ST_STOP  = 2'd3                // stop bit sample
    } rx_state_e;

    typedef struct packed {
        logic       frame_err;         // stop bit was low
        logic [7:0] data;              // received byte
    } uart_frame_t;

    typedef struct packed {
        logic                  overrun; // sticky, frame dropped while full
        logic                  full;
        logic                  empty;
        logic [FIFO_CNT_W-1:0] count;   // entries held
    } fifo_status_t;

endpackage

`default_nettype wire

//--- src/uart_config.svh
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// system clock in Hz
`define UART_CLK_FREQ 25000000

// line rate, 16 clocks per bit at 25 MHz
`define UART_BAUD 1562500

// clocks per serial bit
`define UART_BIT_CYCLES (`UART_CLK_FREQ / `UART_BAUD)

// receive FIFO entries, power of two, at most 16
`define UART_FIFO_DEPTH 8

`endif
